// File: logic/l2_sim_pkg.sv
package l2_sim_pkg;

    ////////////////////
    // bus widths

    // word address, byte address bits [31:2]
    typedef logic [29:0] word_addr_t;

    // one data word
    typedef logic [31:0] data_t;

    // one enable per byte lane of data_t
    typedef logic [3:0] byte_en_t;

    // tag chosen by the requester, echoed on read return
    typedef logic [1:0] sub_id_t;

    // which of the two requesters
    typedef logic [0:0] port_id_t;

    ////////////////////
    // address map

    // uart data register, byte address 0x1000
    localparam word_addr_t UART_WORD_ADDR = 30'h0000_0400;

endpackage

// File: logic/l2_req_if.sv
`timescale 1ns/1ps

// one credited request stream
// push is a single-cycle strobe, credit comes back one per freed slot
interface l2_req_if;

    l2_sim_pkg::word_addr_t addr;
    l2_sim_pkg::byte_en_t be;
    logic rnw;
    l2_sim_pkg::data_t wr_data;
    l2_sim_pkg::sub_id_t sub_id;
    // source port, only meaningful after the arbiter
    l2_sim_pkg::port_id_t port;
    logic push;
    logic credit;

    // sender side
    modport requester (
        output addr, be, rnw, wr_data, sub_id, port, push,
        input credit
    );

    // receiver side, used by the arbiter and by the bridge
    modport arbiter (
        input addr, be, rnw, wr_data, sub_id, port, push,
        output credit
    );

endinterface

// File: logic/axi_lite_if.sv
`timescale 1ns/1ps

// single-beat axi-lite channels, byte addresses
interface axi_lite_if;

    // read address
    logic arvalid;
    logic arready;
    logic [31:0] araddr;

    // read data
    logic rvalid;
    logic rready;
    l2_sim_pkg::data_t rdata;

    // write address
    logic awvalid;
    logic awready;
    logic [31:0] awaddr;

    // write data
    logic wvalid;
    logic wready;
    l2_sim_pkg::data_t wdata;
    l2_sim_pkg::byte_en_t wstrb;

    // write response
    logic bvalid;
    logic bready;

    modport master (
        output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input arready, rvalid, rdata, awready, wready, bvalid
    );

    modport slave (
        input arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output arready, rvalid, rdata, awready, wready, bvalid
    );

endinterface

// File: logic/l2_arbiter.sv
`timescale 1ns/1ps

module l2_arbiter #(
    parameter int REQ_DEPTH = 4,
    parameter int BRIDGE_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    l2_req_if.arbiter req0,
    l2_req_if.arbiter req1,
    l2_req_if.requester out_req
);

    // entry is {addr, be, rnw, wr_data, sub_id}
    localparam int ENTRY_W = $bits(l2_sim_pkg::word_addr_t) + $bits(l2_sim_pkg::byte_en_t)
        + 1 + $bits(l2_sim_pkg::data_t) + $bits(l2_sim_pkg::sub_id_t);
    localparam int PTR_W = $clog2(REQ_DEPTH);
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);
    localparam int CRED_W = $clog2(BRIDGE_DEPTH + 1);

    logic [ENTRY_W-1:0] in_entry [2];
    logic [1:0] in_push;
    logic [ENTRY_W-1:0] q_mem [2][REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr [2];
    logic [PTR_W-1:0] rd_ptr [2];
    logic [CNT_W-1:0] q_count [2];
    logic [1:0] q_valid;
    logic [1:0] pop;
    logic [CRED_W-1:0] dn_credits;
    l2_sim_pkg::port_id_t grant;
    l2_sim_pkg::port_id_t last_grant;
    logic fwd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // gather both ports so one loop serves them
    assign in_push = {req1.push, req0.push};
    assign in_entry[0] = {req0.addr, req0.be, req0.rnw, req0.wr_data, req0.sub_id};
    assign in_entry[1] = {req1.addr, req1.be, req1.rnw, req1.wr_data, req1.sub_id};

    // a slot frees up the cycle its entry is forwarded
    assign req0.credit = pop[0];
    assign req1.credit = pop[1];

    ////////////////////
    // per-port queues

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (in_push[p])
                q_mem[p][wr_ptr[p]] <= in_entry[p];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < 2; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                q_count[p] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (in_push[p])
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                if (pop[p])
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                // push and pop together leave the count alone
                if (in_push[p] && !pop[p])
                    q_count[p] <= q_count[p] + 1'b1;
                else if (!in_push[p] && pop[p])
                    q_count[p] <= q_count[p] - 1'b1;
            end
        end
    end

    ////////////////////
    // round-robin select

    assign q_valid[0] = (q_count[0] != '0);
    assign q_valid[1] = (q_count[1] != '0);

    always_comb begin
        // tie goes to the port not served last
        if (q_valid == 2'b11)
            grant = ~last_grant;
        else if (q_valid[1])
            grant = 1'b1;
        else
            grant = 1'b0;
    end

    // forward only with a bridge slot in hand
    assign fwd = (q_valid != 2'b00) && (dn_credits != '0);
    assign pop[0] = fwd && (grant == 1'b0);
    assign pop[1] = fwd && (grant == 1'b1);

    assign out_req.push = fwd;
    assign out_req.port = grant;
    assign {out_req.addr, out_req.be, out_req.rnw, out_req.wr_data, out_req.sub_id}
        = q_mem[grant][rd_ptr[grant]];

    always_ff @(posedge clk) begin
        if (rst) begin
            dn_credits <= CRED_W'(BRIDGE_DEPTH);
            // port 0 wins the first tie
            last_grant <= 1'b1;
        end else begin
            if (fwd && !out_req.credit)
                dn_credits <= dn_credits - 1'b1;
            else if (!fwd && out_req.credit)
                dn_credits <= dn_credits + 1'b1;
            if (fwd)
                last_grant <= grant;
        end
    end

endmodule

// File: logic/l2_mem_bridge.sv
`timescale 1ns/1ps

module l2_mem_bridge #(
    parameter int BRIDGE_DEPTH = 2
) (
    input logic clk,
    input logic rst,
    l2_req_if.arbiter in_req,
    axi_lite_if.master mem,
    output l2_sim_pkg::data_t rd_data,
    output l2_sim_pkg::sub_id_t rd_sub_id,
    output l2_sim_pkg::port_id_t rd_port,
    output logic rd_valid
);

    // entry is {addr, be, rnw, wr_data, sub_id, port}
    localparam int ENTRY_W = $bits(l2_sim_pkg::word_addr_t) + $bits(l2_sim_pkg::byte_en_t)
        + 1 + $bits(l2_sim_pkg::data_t) + $bits(l2_sim_pkg::sub_id_t)
        + $bits(l2_sim_pkg::port_id_t);
    localparam int PTR_W = $clog2(BRIDGE_DEPTH);
    localparam int CNT_W = $clog2(BRIDGE_DEPTH + 1);

    typedef enum logic [2:0] {
        idle,
        read_addr,
        read_wait,
        write_addr_data,
        write_resp
    } state_t;

    state_t state;
    logic [ENTRY_W-1:0] buf_mem [BRIDGE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] buf_count;
    logic pop;
    logic aw_done;

    l2_sim_pkg::word_addr_t head_addr;
    l2_sim_pkg::byte_en_t head_be;
    logic head_rnw;
    l2_sim_pkg::data_t head_data;
    l2_sim_pkg::sub_id_t head_sub_id;
    l2_sim_pkg::port_id_t head_port;

    // transaction in flight
    l2_sim_pkg::word_addr_t cur_addr;
    l2_sim_pkg::byte_en_t cur_be;
    l2_sim_pkg::data_t cur_data;
    l2_sim_pkg::sub_id_t cur_sub_id;
    l2_sim_pkg::port_id_t cur_port;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BRIDGE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////
    // input buffer

    assign {head_addr, head_be, head_rnw, head_data, head_sub_id, head_port} = buf_mem[rd_ptr];

    // head leaves the buffer when a new transaction starts
    assign pop = (state == idle) && (buf_count != '0);
    assign in_req.credit = pop;

    always_ff @(posedge clk) begin
        if (in_req.push)
            buf_mem[wr_ptr] <= {in_req.addr, in_req.be, in_req.rnw, in_req.wr_data,
                                in_req.sub_id, in_req.port};
        if (pop) begin
            cur_addr <= head_addr;
            cur_be <= head_be;
            cur_data <= head_data;
            cur_sub_id <= head_sub_id;
            cur_port <= head_port;
        end
        // read return carries the tag of the one transaction in flight
        if (mem.rvalid && mem.rready) begin
            rd_data <= mem.rdata;
            rd_sub_id <= cur_sub_id;
            rd_port <= cur_port;
        end
    end

    ////////////////////
    // transaction FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            buf_count <= '0;
            state <= idle;
            aw_done <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (in_req.push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (in_req.push && !pop)
                buf_count <= buf_count + 1'b1;
            else if (!in_req.push && pop)
                buf_count <= buf_count - 1'b1;

            rd_valid <= mem.rvalid && mem.rready;

            case (state)
                idle: begin
                    if (pop)
                        state <= head_rnw ? read_addr : write_addr_data;
                end
                read_addr: begin
                    if (mem.arready)
                        state <= read_wait;
                end
                read_wait: begin
                    if (mem.rvalid)
                        state <= idle;
                end
                write_addr_data: begin
                    // aw and w complete independently
                    if (mem.awvalid && mem.awready)
                        aw_done <= 1'b1;
                    if (mem.wvalid && mem.wready) begin
                        aw_done <= 1'b0;
                        state <= write_resp;
                    end
                end
                write_resp: begin
                    if (mem.bvalid)
                        state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    assign mem.arvalid = (state == read_addr);
    assign mem.araddr = {cur_addr, 2'b00};
    assign mem.awvalid = (state == write_addr_data) && !aw_done;
    assign mem.awaddr = {cur_addr, 2'b00};
    // responder holds wready low until its latency expires
    assign mem.wvalid = (state == write_addr_data);
    assign mem.wdata = cur_data;
    assign mem.wstrb = cur_be;
    // requesters only issue reads they can absorb
    assign mem.rready = 1'b1;
    assign mem.bready = 1'b1;

endmodule

// File: logic/axi_latency_responder.sv
`timescale 1ns/1ps

module axi_latency_responder #(
    parameter int READ_LATENCY = 5,
    parameter int WRITE_LATENCY = 5,
    parameter int MEM_WORDS = 256
) (
    input logic clk,
    input logic rst,
    axi_lite_if.slave mem,
    output logic write_uart,
    output logic [7:0] uart_byte
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int RD_CNT_W = $clog2(READ_LATENCY + 1);
    localparam int WR_CNT_W = $clog2(WRITE_LATENCY + 1);

    l2_sim_pkg::data_t mem_words [MEM_WORDS];
    l2_sim_pkg::word_addr_t rd_addr;
    l2_sim_pkg::word_addr_t wr_addr;
    logic [RD_CNT_W-1:0] rd_count;
    logic [WR_CNT_W-1:0] wr_count;
    logic rd_busy;
    logic wr_busy;
    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic w_fire;
    logic rd_done;
    logic wr_done;
    logic wr_is_uart;

    assign ar_fire = mem.arvalid && mem.arready;
    assign r_fire = mem.rvalid && mem.rready;
    assign aw_fire = mem.awvalid && mem.awready;
    assign w_fire = mem.wvalid && mem.wready;
    assign rd_done = rd_busy && (rd_count == '0);
    assign wr_done = wr_busy && (wr_count == '0);
    // uart register is outside the word memory
    assign wr_is_uart = (wr_addr == l2_sim_pkg::UART_WORD_ADDR);

    ////////////////////
    // read side

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.arready <= 1'b1;
            mem.rvalid <= 1'b0;
            rd_busy <= 1'b0;
            rd_count <= '0;
        end else begin
            if (r_fire)
                mem.rvalid <= 1'b0;
            // countdown ends one cycle before rvalid rises
            if (ar_fire) begin
                mem.arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_count <= RD_CNT_W'(READ_LATENCY - 1);
            end else if (rd_done) begin
                rd_busy <= 1'b0;
                mem.rvalid <= 1'b1;
                mem.arready <= 1'b1;
            end else if (rd_busy) begin
                rd_count <= rd_count - 1'b1;
            end
        end
    end

    ////////////////////
    // write side

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.awready <= 1'b1;
            mem.wready <= 1'b0;
            mem.bvalid <= 1'b0;
            wr_busy <= 1'b0;
            wr_count <= '0;
            write_uart <= 1'b0;
        end else begin
            write_uart <= w_fire && wr_is_uart;
            if (mem.bvalid && mem.bready)
                mem.bvalid <= 1'b0;
            // response follows the data beat
            if (w_fire) begin
                mem.wready <= 1'b0;
                mem.awready <= 1'b1;
                mem.bvalid <= 1'b1;
            end
            if (aw_fire) begin
                mem.awready <= 1'b0;
                wr_busy <= 1'b1;
                wr_count <= WR_CNT_W'(WRITE_LATENCY - 1);
            end else if (wr_done) begin
                wr_busy <= 1'b0;
                mem.wready <= 1'b1;
            end else if (wr_busy) begin
                wr_count <= wr_count - 1'b1;
            end
        end
    end

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_addr <= mem.araddr[31:2];
        if (aw_fire)
            wr_addr <= mem.awaddr[31:2];
        // low address bits index the memory
        if (rd_done)
            mem.rdata <= mem_words[rd_addr[IDX_W-1:0]];
        if (w_fire && wr_is_uart)
            uart_byte <= mem.wdata[7:0];
        if (w_fire && !wr_is_uart) begin
            for (int b = 0; b < $bits(l2_sim_pkg::byte_en_t); b++) begin
                if (mem.wstrb[b])
                    mem_words[wr_addr[IDX_W-1:0]][b*8 +: 8] <= mem.wdata[b*8 +: 8];
            end
        end
    end

endmodule

// File: logic/l2_sim_top.sv
`timescale 1ns/1ps

module l2_sim_top #(
    parameter int REQ_DEPTH = 4,
    parameter int BRIDGE_DEPTH = 2,
    parameter int READ_LATENCY = 5,
    parameter int WRITE_LATENCY = 5,
    parameter int MEM_WORDS = 256
) (
    input logic clk,
    input logic rst,

    // requester 0
    input l2_sim_pkg::word_addr_t p0_addr,
    input l2_sim_pkg::byte_en_t p0_be,
    input logic p0_rnw,
    input l2_sim_pkg::data_t p0_wr_data,
    input l2_sim_pkg::sub_id_t p0_sub_id,
    input logic p0_push,
    output logic p0_credit,

    // requester 1
    input l2_sim_pkg::word_addr_t p1_addr,
    input l2_sim_pkg::byte_en_t p1_be,
    input logic p1_rnw,
    input l2_sim_pkg::data_t p1_wr_data,
    input l2_sim_pkg::sub_id_t p1_sub_id,
    input logic p1_push,
    output logic p1_credit,

    // read return, shared by both requesters
    output l2_sim_pkg::data_t rd_data,
    output l2_sim_pkg::sub_id_t rd_sub_id,
    output l2_sim_pkg::port_id_t rd_port,
    output logic rd_valid,

    output logic write_uart,
    output logic [7:0] uart_byte
);

    l2_req_if req0();
    l2_req_if req1();
    l2_req_if arb_to_bridge();
    axi_lite_if mem_bus();

    ////////////////////
    // requester ports

    assign req0.addr = p0_addr;
    assign req0.be = p0_be;
    assign req0.rnw = p0_rnw;
    assign req0.wr_data = p0_wr_data;
    assign req0.sub_id = p0_sub_id;
    assign req0.port = 1'b0;
    assign req0.push = p0_push;
    assign p0_credit = req0.credit;

    assign req1.addr = p1_addr;
    assign req1.be = p1_be;
    assign req1.rnw = p1_rnw;
    assign req1.wr_data = p1_wr_data;
    assign req1.sub_id = p1_sub_id;
    assign req1.port = 1'b1;
    assign req1.push = p1_push;
    assign p1_credit = req1.credit;

    ////////////////////
    // datapath

    l2_arbiter #(
        .REQ_DEPTH(REQ_DEPTH),
        .BRIDGE_DEPTH(BRIDGE_DEPTH)
    ) arbiter (
        .clk(clk),
        .rst(rst),
        .req0(req0),
        .req1(req1),
        .out_req(arb_to_bridge)
    );

    l2_mem_bridge #(
        .BRIDGE_DEPTH(BRIDGE_DEPTH)
    ) bridge (
        .clk(clk),
        .rst(rst),
        .in_req(arb_to_bridge),
        .mem(mem_bus),
        .rd_data(rd_data),
        .rd_sub_id(rd_sub_id),
        .rd_port(rd_port),
        .rd_valid(rd_valid)
    );

    axi_latency_responder #(
        .READ_LATENCY(READ_LATENCY),
        .WRITE_LATENCY(WRITE_LATENCY),
        .MEM_WORDS(MEM_WORDS)
    ) responder (
        .clk(clk),
        .rst(rst),
        .mem(mem_bus),
        .write_uart(write_uart),
        .uart_byte(uart_byte)
    );

endmodule

// File: tb/l2_sim_tb.sv
`timescale 1ns/1ps

module l2_sim_tb;

    localparam int REQ_DEPTH = 4;
    // 64 init writes, random mix, one closing read per port
    localparam int INIT_REQS = 64;
    localparam int RAND_REQS = 150;
    localparam int PORT_REQS = INIT_REQS + RAND_REQS + 1;
    // about 430 requests at roughly 14 cycles each, with ample margin
    localparam int MAX_CYCLES = 40000;

    logic clk;
    logic rst;
    l2_sim_pkg::word_addr_t p0_addr;
    l2_sim_pkg::byte_en_t p0_be;
    logic p0_rnw;
    l2_sim_pkg::data_t p0_wr_data;
    l2_sim_pkg::sub_id_t p0_sub_id;
    logic p0_push;
    logic p0_credit;
    l2_sim_pkg::word_addr_t p1_addr;
    l2_sim_pkg::byte_en_t p1_be;
    logic p1_rnw;
    l2_sim_pkg::data_t p1_wr_data;
    l2_sim_pkg::sub_id_t p1_sub_id;
    logic p1_push;
    logic p1_credit;
    l2_sim_pkg::data_t rd_data;
    l2_sim_pkg::sub_id_t rd_sub_id;
    l2_sim_pkg::port_id_t rd_port;
    logic rd_valid;
    logic write_uart;
    logic [7:0] uart_byte;

    // reference memory, words 0..63 for port 0 and 64..127 for port 1
    l2_sim_pkg::data_t ref_mem [128];
    // expected read returns as {sub_id, data}
    logic [33:0] exp_q0 [$];
    logic [33:0] exp_q1 [$];
    logic [7:0] uart_q [$];
    int credits [2];
    int pushes [2];
    int credit_pulses [2];
    int issued [2];
    int cycles = 0;

    // registered results, checked by the assertions one edge later
    logic rd_chk;
    logic rd_unexp;
    logic [33:0] rd_exp;
    logic [33:0] rd_got;
    logic uart_chk;
    logic uart_unexp;
    logic [7:0] uart_exp;
    logic [7:0] uart_got;

    l2_sim_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "stopped at first failing check");
    endtask

    // init pattern, every address bit shows up in the word
    function automatic l2_sim_pkg::data_t fill_word(input l2_sim_pkg::word_addr_t addr);
        return {addr, 2'b11} ^ 32'h9e37_79b9;
    endfunction

    function automatic l2_sim_pkg::data_t merge_bytes(input l2_sim_pkg::data_t old_word,
            input l2_sim_pkg::data_t new_word, input l2_sim_pkg::byte_en_t be);
        l2_sim_pkg::data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    ////////////////////
    // stimulus

    // one push per cycle while a credit is held
    task automatic drive_port(input int p);
        l2_sim_pkg::word_addr_t addr;
        l2_sim_pkg::byte_en_t be;
        l2_sim_pkg::data_t data;
        l2_sim_pkg::sub_id_t sub;
        logic rnw;
        logic push;
        logic [31:0] r;
        push = (credits[p] > 0) && (issued[p] < PORT_REQS);
        addr = '0;
        be = 4'hf;
        rnw = 1'b0;
        data = '0;
        sub = l2_sim_pkg::sub_id_t'(issued[p]);
        if (push) begin
            r = $urandom;
            data = $urandom;
            if (issued[p] < INIT_REQS) begin
                addr = l2_sim_pkg::word_addr_t'(p * 64 + issued[p]);
                data = fill_word(addr);
            end else if (issued[p] == PORT_REQS - 1) begin
                // word 0 shares its memory index with the uart register
                addr = l2_sim_pkg::word_addr_t'(p * 64);
                rnw = 1'b1;
            end else if (p == 0 && (issued[p] == INIT_REQS || r[15:12] == 4'h0)) begin
                addr = l2_sim_pkg::UART_WORD_ADDR;
            end else begin
                addr = l2_sim_pkg::word_addr_t'(p * 64) + l2_sim_pkg::word_addr_t'(r[5:0]);
                rnw = r[6];
                // partial enables, zero included
                be = r[11:8];
            end
            if (rnw && p == 0)
                exp_q0.push_back({sub, ref_mem[addr[6:0]]});
            else if (rnw)
                exp_q1.push_back({sub, ref_mem[addr[6:0]]});
            else if (addr == l2_sim_pkg::UART_WORD_ADDR)
                uart_q.push_back(data[7:0]);
            else
                ref_mem[addr[6:0]] = merge_bytes(ref_mem[addr[6:0]], data, be);
            credits[p]--;
            pushes[p]++;
            issued[p]++;
        end
        if (p == 0) begin
            p0_push <= push;
            p0_addr <= addr;
            p0_be <= be;
            p0_rnw <= rnw;
            p0_wr_data <= data;
            p0_sub_id <= sub;
        end else begin
            p1_push <= push;
            p1_addr <= addr;
            p1_be <= be;
            p1_rnw <= rnw;
            p1_wr_data <= data;
            p1_sub_id <= sub;
        end
    endtask

    ////////////////////
    // response capture

    task automatic check_returns();
        rd_chk <= 1'b0;
        rd_unexp <= 1'b0;
        uart_chk <= 1'b0;
        uart_unexp <= 1'b0;
        if (rd_valid) begin
            if ((rd_port == 1'b0 && exp_q0.size() == 0) ||
                    (rd_port == 1'b1 && exp_q1.size() == 0)) begin
                rd_unexp <= 1'b1;
            end else begin
                rd_chk <= 1'b1;
                rd_got <= {rd_sub_id, rd_data};
                if (rd_port == 1'b0)
                    rd_exp <= exp_q0.pop_front();
                else
                    rd_exp <= exp_q1.pop_front();
            end
        end
        if (write_uart) begin
            if (uart_q.size() == 0) begin
                uart_unexp <= 1'b1;
            end else begin
                uart_chk <= 1'b1;
                uart_got <= uart_byte;
                uart_exp <= uart_q.pop_front();
            end
        end
        // a pulse hands one slot back
        if (p0_credit) begin
            credits[0]++;
            credit_pulses[0]++;
        end
        if (p1_credit) begin
            credits[1]++;
            credit_pulses[1]++;
        end
    endtask

    initial begin
        logic done;
        void'($urandom(32'h1006_5a3f));
        rst = 1'b1;
        p0_addr = '0;
        p0_be = '0;
        p0_rnw = 1'b0;
        p0_wr_data = '0;
        p0_sub_id = '0;
        p0_push = 1'b0;
        p1_addr = '0;
        p1_be = '0;
        p1_rnw = 1'b0;
        p1_wr_data = '0;
        p1_sub_id = '0;
        p1_push = 1'b0;
        rd_chk = 1'b0;
        rd_unexp = 1'b0;
        uart_chk = 1'b0;
        uart_unexp = 1'b0;
        for (int p = 0; p < 2; p++) begin
            credits[p] = REQ_DEPTH;
            pushes[p] = 0;
            credit_pulses[p] = 0;
            issued[p] = 0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            check_returns();
            drive_port(0);
            drive_port(1);
            done = (issued[0] == PORT_REQS) && (issued[1] == PORT_REQS) &&
                (exp_q0.size() == 0) && (exp_q1.size() == 0) && (uart_q.size() == 0) &&
                (credits[0] == REQ_DEPTH) && (credits[1] == REQ_DEPTH);
        end
        // let the last strobes reach the assertions, catch stray pulses
        repeat (2) begin
            @(posedge clk);
            check_returns();
        end
        // last capture is judged on this edge
        @(posedge clk);
        @(negedge clk);
        if (credit_pulses[0] == pushes[0] && credit_pulses[1] == pushes[1]) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Error: credit_balance expected %0d %0d actual %0d %0d",
                pushes[0], pushes[1], credit_pulses[0], credit_pulses[1]);
            abort_run();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: traffic still pending after %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    ////////////////////
    // checks

    // first edge skipped, outputs are still unknown there
    assert property (@(posedge clk) (cycles >= 1 && (rst || $past(rst)))
            |-> !(rd_valid || write_uart || p0_credit || p1_credit))
    else begin
        $display("Error: reset_idle expected 0000 actual %b%b%b%b", $sampled(rd_valid),
            $sampled(write_uart), $sampled(p0_credit), $sampled(p1_credit));
        abort_run();
    end

    assert property (@(posedge clk) credits[0] >= 0 && credits[0] <= REQ_DEPTH)
    else begin
        $display("Error: credit_range port 0 expected 0..%0d actual %0d",
            REQ_DEPTH, $sampled(credits[0]));
        abort_run();
    end

    assert property (@(posedge clk) credits[1] >= 0 && credits[1] <= REQ_DEPTH)
    else begin
        $display("Error: credit_range port 1 expected 0..%0d actual %0d",
            REQ_DEPTH, $sampled(credits[1]));
        abort_run();
    end

    // {sub_id, data} against the reference
    assert property (@(posedge clk) rd_chk |-> rd_got == rd_exp)
    else begin
        $display("Error: read_return expected %h actual %h", $sampled(rd_exp), $sampled(rd_got));
        abort_run();
    end

    assert property (@(posedge clk) !rd_unexp)
    else begin
        $display("read data came back on a port with no read outstanding");
        abort_run();
    end

    assert property (@(posedge clk) uart_chk |-> uart_got == uart_exp)
    else begin
        $display("Error: uart_byte expected %h actual %h", $sampled(uart_exp),
            $sampled(uart_got));
        abort_run();
    end

    assert property (@(posedge clk) !uart_unexp)
    else begin
        $display("write_uart pulsed without a pending uart write");
        abort_run();
    end

endmodule

// File: build.f
logic/l2_sim_pkg.sv
logic/l2_req_if.sv
logic/axi_lite_if.sv
logic/l2_arbiter.sv
logic/l2_mem_bridge.sv
logic/axi_latency_responder.sv
logic/l2_sim_top.sv
tb/l2_sim_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := l2_sim_tb
FILELIST := build.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
